// ==== Bender.yml ====
package:
  name: board_console

sources:
  - board_pkg.sv
  - uart_tx.sv
  - uart_rx.sv
  - console_echo.sv
  - activity_leds.sv
  - board_top.sv
  - target: simulation
    files:
      - tb_board_top.sv

// ==== activity_leds.sv ====
module activity_leds (
  input  logic              clock,
  input  logic              arst_n,
  input  logic              rx_strobe,
  input  logic              tx_strobe,
  input  board_pkg::level_t level,
  output logic [7:0]        user_led
);

  logic [1:0] rx_count;    // Bytes accepted, wraps
  logic [1:0] tx_count;    // Bytes sent, wraps
  logic [1:0] rx_next;
  logic [1:0] tx_next;
  logic [7:0] leds;        // Logical LED word, 1 is lit

  assign rx_next = rx_count + {1'b0, rx_strobe};
  assign tx_next = tx_count + {1'b0, tx_strobe};

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rx_count <= '0;
      tx_count <= '0;
      leds     <= '0;                         // All off
    end else begin
      rx_count <= rx_next;
      tx_count <= tx_next;
      leds     <= {level, tx_next, rx_next};  // Shows the new counts at once
    end
  end

  // ----------------------------------------------------------------------
  // Pin mapping
  // ----------------------------------------------------------------------

  // LEDs sink current and the row is mounted facing the other way
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      user_led[i] = ~leds[7 - i];             // Mirror and invert
    end
  end

endmodule

// ==== board_pkg.sv ====
package board_pkg;

  // ----------------------------------------------------------------------
  // Data widths
  // ----------------------------------------------------------------------

  typedef logic [7:0] byte_t;    // One character on the serial line
  typedef logic [3:0] level_t;   // Queue fill level shown on the LEDs

  // ----------------------------------------------------------------------
  // State machines
  // ----------------------------------------------------------------------

  typedef enum logic [1:0] {
    tx_idle,                     // Line high and ready for a byte
    tx_start_bit,                // Driving the low start bit
    tx_data_bits,                // Eight data bits LSB first
    tx_stop_bit                  // Driving the high stop bit
  } tx_state_t;

  typedef enum logic [2:0] {
    rx_idle,                     // Waiting for a falling edge
    rx_start_bit,                // Half bit wait to confirm start
    rx_data_bits,                // Sampling eight bits at mid bit
    rx_stop_bit,                 // Sampling the stop bit
    rx_hold_check                // Hand byte over or flag overflow
  } rx_state_t;

endpackage

// ==== board_top.sv ====
module board_top #(
  parameter int clock_frequency = 50_000_000,
  parameter int bps             = 115200,
  parameter int fifo_depth      = 4
) (
  input  logic       clock,
  input  logic       arst_n,
  input  logic       serial_in,
  output logic       serial_out,
  input  logic [3:0] dip_sw,
  output logic [7:0] user_led,
  output logic       rx_overflow
);

  board_pkg::byte_t  rx_data;
  logic              rx_valid;
  logic              rx_ready;
  board_pkg::byte_t  tx_data;
  logic              tx_valid;
  logic              tx_ready;
  board_pkg::level_t level;       // Queue fill for the LEDs
  logic              rx_strobe;   // Byte accepted from receiver
  logic              tx_strobe;   // Byte handed to transmitter

  assign rx_strobe = rx_valid && rx_ready;
  assign tx_strobe = tx_valid && tx_ready;

  // ----------------------------------------------------------------------
  // Serial path
  // ----------------------------------------------------------------------

  uart_rx #(
    .clock_frequency (clock_frequency),
    .bps             (bps)
  ) u_uart_rx (
    .clock     (clock),
    .arst_n    (arst_n),
    .serial_in (serial_in),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid),
    .rx_ready  (rx_ready),
    .overflow  (rx_overflow)
  );

  console_echo #(
    .fifo_depth (fifo_depth)
  ) u_console_echo (
    .clock    (clock),
    .arst_n   (arst_n),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_ready (rx_ready),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .pause    (dip_sw[0]),       // Switch 0 holds transmission
    .level    (level)
  );

  uart_tx #(
    .clock_frequency (clock_frequency),
    .bps             (bps)
  ) u_uart_tx (
    .clock      (clock),
    .arst_n     (arst_n),
    .tx_data    (tx_data),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .serial_out (serial_out)
  );

  // Status display
  activity_leds u_activity_leds (
    .clock     (clock),
    .arst_n    (arst_n),
    .rx_strobe (rx_strobe),
    .tx_strobe (tx_strobe),
    .level     (level),
    .user_led  (user_led)
  );

endmodule

// ==== console_echo.sv ====
module console_echo #(
  parameter int fifo_depth = 4
) (
  input  logic              clock,
  input  logic              arst_n,
  input  board_pkg::byte_t  rx_data,
  input  logic              rx_valid,
  output logic              rx_ready,
  output board_pkg::byte_t  tx_data,
  output logic              tx_valid,
  input  logic              tx_ready,
  input  logic              pause,
  output board_pkg::level_t level
);

  localparam int ptr_w = $clog2(fifo_depth);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(fifo_depth - 1);
  localparam board_pkg::level_t full_level = board_pkg::level_t'(fifo_depth);

  board_pkg::byte_t  mem [fifo_depth];   // Character queue
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  board_pkg::level_t count;              // Entries in use
  logic              push;
  logic              pop;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  function automatic board_pkg::byte_t to_upper(input board_pkg::byte_t c);
    if (c >= 8'h61 && c <= 8'h7a) return c - 8'h20;  // Letters a to z only
    return c;
  endfunction

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
    return (p == last_ptr) ? '0 : p + 1'b1;        // Wraps for any depth
  endfunction

  // ----------------------------------------------------------------------
  // Handshakes
  // ----------------------------------------------------------------------

  assign push     = rx_valid && rx_ready;
  assign pop      = tx_valid && tx_ready;
  assign rx_ready = (count != full_level);         // Back pressure when full
  assign tx_valid = (count != '0) && !pause;       // Pause freezes output only
  assign tx_data  = mem[rd_ptr];                   // Head of queue
  assign level    = count;

  // Storage
  always_ff @(posedge clock) begin
    if (push) mem[wr_ptr] <= to_upper(rx_data);    // Convert on the way in
  end

  // Pointers and fill count
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop)  rd_ptr <= next_ptr(rd_ptr);
      unique case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                   // Both or neither
      endcase
    end
  end

endmodule

// ==== tb_board_top.sv ====
module tb_board_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clock_frequency = 1_000_000;
  localparam int bps             = 100_000;
  localparam int fifo_depth      = 4;
  localparam int cycles_per_bit  = clock_frequency / bps;
  localparam int num_bytes       = 40;               // Random echo run
  localparam int burst           = fifo_depth + 1;   // Fills queue plus rx holding register
  localparam int total_frames    = 2 * num_bytes + 2 * burst + 1;
  localparam int watchdog_cycles = total_frames * 10 * cycles_per_bit * 3 / 2;

  logic        clock;
  logic        arst_n;
  logic        serial_in;
  logic        serial_out;
  logic [3:0]  dip_sw;
  logic [7:0]  user_led;
  logic        rx_overflow;
  logic [15:0] lfsr_state;     // Galois LFSR, one step per bit
  logic [7:0]  model_q[$];     // Expected echo bytes in order
  int          echo_count;     // Frames decoded from serial_out
  int          accepted;       // Bytes taken into the queue
  int          error_count;

  board_top #(
    .clock_frequency (clock_frequency),
    .bps             (bps),
    .fifo_depth      (fifo_depth)
  ) u_dut (
    .clock       (clock),
    .arst_n      (arst_n),
    .serial_in   (serial_in),
    .serial_out  (serial_out),
    .dip_sw      (dip_sw),
    .user_led    (user_led),
    .rx_overflow (rx_overflow)
  );

  always #10 clock = ~clock;   // 20 ns period

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("** Error at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);   // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic int random_bits(input int n);
    int value;
    value = 0;
    for (int i = 0; i < n; i++) begin
      value      = (value << 1) | lfsr_state[0];   // Take the output bit
      lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
  endfunction

  // Half the characters are forced into a..z so conversion gets exercised
  function automatic logic [7:0] random_char();
    if (random_bits(1) == 1) return 8'(8'h61 + random_bits(5) % 26);
    return 8'(random_bits(8));
  endfunction

  function automatic logic [7:0] expected_echo(input logic [7:0] c);
    string upper;
    upper = "ABCDEFGHIJKLMNOPQRSTUVWXYZ";
    if (c >= "a" && c <= "z") return upper[c - "a"];   // Same letter in upper case
    return c;
  endfunction

  function automatic logic [7:0] led_pins(input int level, input int tx_bytes,
                                          input int rx_bytes);
    logic [7:0] word;
    logic [7:0] pins;
    word = {level[3:0], tx_bytes[1:0], rx_bytes[1:0]};
    for (int i = 0; i < 8; i++) pins[i] = ~word[7 - i];   // Mirrored, active low
    return pins;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clock);
    #2;                                            // Drive point after the edge
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};                       // Stop, data LSB first, start
    for (int i = 0; i < 10; i++) begin
      serial_in = frame[i];
      idle_cycles(cycles_per_bit);
    end
  endtask

  // ----------------------------------------------------------------------
  // Host receiver
  // ----------------------------------------------------------------------

  task automatic watch_line();
    logic [7:0] data;
    logic [7:0] head;
    forever begin
      @(negedge serial_out);                       // Start bit edge
      repeat (cycles_per_bit / 2) @(negedge clock);
      check_value("serial_out start bit", 0, serial_out);
      for (int i = 0; i < 8; i++) begin
        repeat (cycles_per_bit) @(negedge clock);
        data[i] = serial_out;                      // Mid bit sample
      end
      repeat (cycles_per_bit) @(negedge clock);
      check_value("serial_out stop bit", 1, serial_out);
      if (model_q.size() == 0) begin
        error_count++;
        $display("A frame came back on serial_out at %0t ns that was never sent", $time);
        $display("STATUS: FAIL");
        $fatal(1, "unexpected frame");
      end
      head = model_q.pop_front();
      check_value("serial_out data", head, data);
      echo_count++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Watchdog
  // ----------------------------------------------------------------------

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("Timeout after %0d cycles, the echo did not complete", watchdog_cycles);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  initial begin
    logic [7:0] b;
    clock       = 1'b0;
    arst_n      = 1'b0;
    serial_in   = 1'b1;                            // Idle line
    dip_sw      = 4'b0000;
    lfsr_state  = 16'd74;
    echo_count  = 0;
    accepted    = 0;
    error_count = 0;
    repeat (8) @(posedge clock);
    #2 arst_n = 1'b1;
    idle_cycles(1);
    check_value("serial_out", 1, serial_out);      // State after reset
    check_value("user_led", 8'hff, user_led);
    check_value("rx_overflow", 0, rx_overflow);
    fork
      watch_line();
    join_none

    for (int n = 0; n < num_bytes; n++) begin      // Random bytes and gaps
      b = random_char();
      model_q.push_back(expected_echo(b));
      send_byte(b);
      accepted++;
      idle_cycles(1 + random_bits(5));
    end
    wait (echo_count == num_bytes);
    idle_cycles(2);
    check_value("user_led", led_pins(0, echo_count, accepted), user_led);

    dip_sw[0] = 1'b1;                              // Pause so the queue fills
    for (int n = 0; n < burst; n++) begin
      b = random_char();
      model_q.push_back(expected_echo(b));
      send_byte(b);
    end
    accepted += fifo_depth;                        // Last one waits in rx
    for (int n = 0; n < 20 * cycles_per_bit; n++) begin
      idle_cycles(1);
      check_value("serial_out", 1, serial_out);
    end
    check_value("rx_overflow", 0, rx_overflow);
    check_value("user_led", led_pins(fifo_depth, echo_count, accepted), user_led);
    send_byte(random_char());                      // Lost while rx still holds a byte
    check_value("rx_overflow", 1, rx_overflow);

    dip_sw[0] = 1'b0;
    accepted++;                                    // Held byte enters the queue
    wait (echo_count == num_bytes + burst);
    idle_cycles(20 * cycles_per_bit);              // No extra frame may follow
    check_value("rx_overflow", 1, rx_overflow);
    check_value("user_led", led_pins(0, echo_count, accepted), user_led);

    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== uart_rx.sv ====
module uart_rx #(
  parameter int clock_frequency = 50_000_000,
  parameter int bps             = 115200
) (
  input  logic             clock,
  input  logic             arst_n,
  input  logic             serial_in,
  output board_pkg::byte_t rx_data,
  output logic             rx_valid,
  input  logic             rx_ready,
  output logic             overflow
);

  localparam int cycles_per_bit = clock_frequency / bps;
  localparam int div_w = (cycles_per_bit > 1) ? $clog2(cycles_per_bit) : 1;
  localparam logic [div_w-1:0] full_load = div_w'(cycles_per_bit - 1);
  localparam logic [div_w-1:0] half_load = div_w'(cycles_per_bit / 2 - 1);

  logic [1:0]           sync;       // Two flop synchronizer
  logic                 line;       // Synchronized line level
  logic                 line_prev;  // Previous level for edge detect
  board_pkg::rx_state_t state;
  logic [div_w-1:0]     div;        // Cycles to next sample point
  logic [2:0]           bit_cnt;    // Data bit index
  board_pkg::byte_t     shift;      // Assembled bits
  logic                 tick;       // Sample point reached
  logic                 sample;     // Take a data bit now
  logic                 blocked;    // Held byte not yet taken
  logic                 load;       // New byte goes to holding register

  assign line    = sync[1];
  assign tick    = (div == '0);
  assign sample  = (state == board_pkg::rx_data_bits) && tick;
  assign blocked = rx_valid && !rx_ready;
  assign load    = (state == board_pkg::rx_hold_check) && !blocked;

  // ----------------------------------------------------------------------
  // Line synchronizer
  // ----------------------------------------------------------------------

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      sync      <= 2'b11;                  // Line idles high
      line_prev <= 1'b1;
    end else begin
      sync      <= {sync[0], serial_in};
      line_prev <= line;
    end
  end

  // ----------------------------------------------------------------------
  // Frame receiver
  // ----------------------------------------------------------------------

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state    <= board_pkg::rx_idle;
      div      <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
      overflow <= 1'b0;
    end else begin
      if (rx_valid && rx_ready) rx_valid <= 1'b0;    // Byte taken by consumer
      unique case (state)
        board_pkg::rx_idle: begin
          if (line_prev && !line) begin            // Falling start edge
            div   <= half_load;
            state <= board_pkg::rx_start_bit;
          end
        end
        board_pkg::rx_start_bit: begin
          if (!tick) div <= div - 1'b1;
          else if (!line) begin                    // Still low at mid bit
            div     <= full_load;
            bit_cnt <= '0;
            state   <= board_pkg::rx_data_bits;
          end else begin
            state <= board_pkg::rx_idle;           // Glitch, not a start
          end
        end
        board_pkg::rx_data_bits: begin
          if (tick) begin
            div     <= full_load;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= board_pkg::rx_stop_bit;
          end else begin
            div <= div - 1'b1;
          end
        end
        board_pkg::rx_stop_bit: begin
          if (!tick) div <= div - 1'b1;
          else if (line) state <= board_pkg::rx_hold_check;  // Good stop bit
          else state <= board_pkg::rx_idle;                  // Framing error
        end
        board_pkg::rx_hold_check: begin
          if (blocked) overflow <= 1'b1;           // Sticky until reset
          else rx_valid <= 1'b1;
          state <= board_pkg::rx_idle;
        end
        default: state <= board_pkg::rx_idle;
      endcase
    end
  end

  // Data path
  always_ff @(posedge clock) begin
    if (sample) shift <= {line, shift[7:1]};  // LSB arrives first
    if (load) rx_data <= shift;
  end

endmodule

// ==== uart_tx.sv ====
module uart_tx #(
  parameter int clock_frequency = 50_000_000,
  parameter int bps             = 115200
) (
  input  logic             clock,
  input  logic             arst_n,
  input  board_pkg::byte_t tx_data,
  input  logic             tx_valid,
  output logic             tx_ready,
  output logic             serial_out
);

  localparam int cycles_per_bit = clock_frequency / bps;
  localparam int div_w = (cycles_per_bit > 1) ? $clog2(cycles_per_bit) : 1;
  localparam logic [div_w-1:0] full_load = div_w'(cycles_per_bit - 1);

  board_pkg::tx_state_t state;
  logic [div_w-1:0]     div;        // Cycles left in the current bit
  logic [2:0]           bit_cnt;    // Data bit index
  board_pkg::byte_t     shift;      // Bits still to be sent
  logic                 tick;       // End of a bit time
  logic                 start;      // Byte accepted this cycle

  assign tick     = (div == '0);
  assign tx_ready = (state == board_pkg::tx_idle);   // Only accept when idle
  assign start    = tx_valid && tx_ready;

  // ----------------------------------------------------------------------
  // Frame sequencer
  // ----------------------------------------------------------------------

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state      <= board_pkg::tx_idle;
      div        <= '0;
      bit_cnt    <= '0;
      serial_out <= 1'b1;                  // Idle line is mark
    end else begin
      unique case (state)
        board_pkg::tx_idle: begin
          if (start) begin
            serial_out <= 1'b0;            // Start bit next cycle
            div        <= full_load;
            state      <= board_pkg::tx_start_bit;
          end
        end
        board_pkg::tx_start_bit: begin
          if (tick) begin
            serial_out <= shift[0];        // First data bit
            div        <= full_load;
            bit_cnt    <= '0;
            state      <= board_pkg::tx_data_bits;
          end else begin
            div <= div - 1'b1;
          end
        end
        board_pkg::tx_data_bits: begin
          if (tick) begin
            div <= full_load;
            if (bit_cnt == 3'd7) begin
              serial_out <= 1'b1;          // Stop bit
              state      <= board_pkg::tx_stop_bit;
            end else begin
              serial_out <= shift[0];
              bit_cnt    <= bit_cnt + 1'b1;
            end
          end else begin
            div <= div - 1'b1;
          end
        end
        board_pkg::tx_stop_bit: begin
          if (tick) state <= board_pkg::tx_idle;   // Ready again after stop
          else div <= div - 1'b1;
        end
        default: state <= board_pkg::tx_idle;
      endcase
    end
  end

  // Payload shifter
  always_ff @(posedge clock) begin
    if (start) shift <= tx_data;                 // Latch at transfer
    else if (tick && state != board_pkg::tx_idle && state != board_pkg::tx_stop_bit)
      shift <= {1'b0, shift[7:1]};               // Next bit into position 0
  end

endmodule

// ==== verilog.f ====
board_pkg.sv
uart_tx.sv
uart_rx.sv
console_echo.sv
activity_leds.sv
board_top.sv
tb_board_top.sv
